/* hw/vtp_addr_pkg.sv */
// Cache-line address definitions

`default_nettype none

package vtp_addr_pkg;

    // ====================
    // Widths
    // ====================

    // Virtual and physical line addresses share one width
    localparam int LINE_ADDR_BITS = 42;

    // Line offset inside a 4 KB page (64 lines)
    localparam int OFFSET_4K_BITS = 6;

    // Line offset inside a 2 MB page (32768 lines)
    localparam int OFFSET_2M_BITS = 15;

    // 4 KB page index is what remains above the small offset
    localparam int PAGE_4K_BITS = LINE_ADDR_BITS - OFFSET_4K_BITS;

    // ====================
    // Types
    // ====================

    typedef logic [LINE_ADDR_BITS-1:0] t_line_addr;
    typedef logic [PAGE_4K_BITS-1:0]   t_page_4k;

    // 4 KB page index of a line address
    function automatic t_page_4k vtp_page_4k(input t_line_addr addr);
        return addr[LINE_ADDR_BITS-1:OFFSET_4K_BITS];
    endfunction

endpackage

`default_nettype wire

/* hw/vtp_req_pkg.sv */
// Read request definitions

`default_nettype none

package vtp_req_pkg;

    // ====================
    // Opcodes
    // ====================

    // Read flavours accepted from the requester
    typedef enum logic [1:0] {
        OP_RD      = 2'd0,  // translated read
        OP_RD_SPEC = 2'd1,  // speculative, failure returns an error
        OP_RD_PHYS = 2'd2   // address is already physical
    } t_rd_op;

    // ====================
    // Request fields
    // ====================

    // Opaque requester metadata, returned with the response
    typedef logic [15:0] t_mdata;

    // Ceiling on the lookup tag count
    localparam int MAX_TAGS = 64;

endpackage

`default_nettype wire

/* hw/vtp_req_decode.sv */
// Request decode and tag allocation

`default_nettype none

module vtp_req_decode
#(
    parameter int N_TAGS = 16
)
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid,
    input  vtp_req_pkg::t_rd_op           req_op,
    input  vtp_addr_pkg::t_line_addr      req_addr,
    input  vtp_req_pkg::t_mdata           req_mdata,
    input  logic                          free_valid,
    input  logic [$clog2(N_TAGS)-1:0]     free_tag,
    output logic                          lookup_valid,
    output logic [$clog2(N_TAGS)-1:0]     lookup_tag,
    output vtp_addr_pkg::t_page_4k        lookup_page,
    output logic                          lookup_spec,
    output logic                          alloc_valid,
    output logic [$clog2(N_TAGS)-1:0]     alloc_tag,
    output vtp_addr_pkg::t_line_addr      alloc_addr,
    output logic                          alloc_phys,
    output logic                          alloc_spec,
    output vtp_req_pkg::t_mdata           alloc_mdata
);
    import vtp_addr_pkg::*;
    import vtp_req_pkg::*;

    localparam int TAG_BITS = $clog2(N_TAGS);

    // Tag count must be a power of two within the supported range
    if ((N_TAGS > MAX_TAGS) || ((N_TAGS & (N_TAGS - 1)) != 0))
    begin : g_bad_n_tags
        $error("N_TAGS must be a power of two no larger than MAX_TAGS");
    end

    // One bit per tag, set while the tag is free
    logic [N_TAGS-1:0]   free_map;
    logic [TAG_BITS-1:0] next_tag;
    logic                is_spec;
    logic                is_phys;

    // ====================
    // Opcode decode
    // ====================

    always_comb
    begin
        is_spec = 1'b0;
        is_phys = 1'b0;
        case (req_op)
            OP_RD:      ;
            OP_RD_SPEC: is_spec = 1'b1;
            OP_RD_PHYS: is_phys = 1'b1;
            default:    ;
        endcase
    end

    // ====================
    // Free tag pool
    // ====================

    // Lowest free tag wins, so scan from the top down
    always_comb
    begin
        next_tag = '0;
        for (int i = N_TAGS - 1; i >= 0; i--)
        begin
            if (free_map[i])
            begin
                next_tag = TAG_BITS'(i);
            end
        end
    end

    // Taken tag is never the one being freed
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            free_map <= '1;
        end
        else
        begin
            if (req_valid)
            begin
                free_map[next_tag] <= 1'b0;
            end
            if (free_valid)
            begin
                free_map[free_tag] <= 1'b1;
            end
        end
    end

    // Lookup leaves in the request cycle
    // Service ignores the page of a physical request
    assign lookup_valid = req_valid;
    assign lookup_tag   = next_tag;
    assign lookup_page  = vtp_page_4k(req_addr);
    assign lookup_spec  = is_spec;

    // ====================
    // Allocation record
    // ====================

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            alloc_valid <= 1'b0;
        end
        else
        begin
            alloc_valid <= req_valid;
        end
    end

    // Payload only, qualified by alloc_valid
    always_ff @(posedge clk)
    begin
        alloc_tag   <= next_tag;
        alloc_addr  <= req_addr;
        alloc_phys  <= is_phys;
        alloc_spec  <= is_spec;
        alloc_mdata <= req_mdata;
    end

    // Requester keeps at most N_TAGS lookups in flight
    a_pool_not_empty: assert property (@(posedge clk) disable iff (!reset)
        req_valid |-> |free_map)
        else $error("Request arrived with no free lookup tag");

endmodule

`default_nettype wire

/* hw/vtp_xlate_execute.sv */
// Translation completion and address build

`default_nettype none

module vtp_xlate_execute
#(
    parameter int N_TAGS = 16
)
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          alloc_valid,
    input  logic [$clog2(N_TAGS)-1:0]     alloc_tag,
    input  vtp_addr_pkg::t_line_addr      alloc_addr,
    input  logic                          alloc_phys,
    input  logic                          alloc_spec,
    input  vtp_req_pkg::t_mdata           alloc_mdata,
    input  logic                          lookup_rsp_valid,
    input  logic [$clog2(N_TAGS)-1:0]     lookup_rsp_tag,
    input  logic                          lookup_rsp_error,
    input  logic                          lookup_rsp_big,
    input  vtp_addr_pkg::t_page_4k        lookup_rsp_page,
    output logic                          free_valid,
    output logic [$clog2(N_TAGS)-1:0]     free_tag,
    output logic                          mem_req_valid,
    output vtp_addr_pkg::t_line_addr      mem_req_addr,
    output vtp_req_pkg::t_mdata           mem_req_mdata,
    output logic                          err_valid,
    output vtp_req_pkg::t_mdata           err_mdata
);
    import vtp_addr_pkg::*;
    import vtp_req_pkg::*;

    // Page bits dropped when a 2 MB page swallows part of the 4 KB index
    localparam int BIG_LOW_BITS = OFFSET_2M_BITS - OFFSET_4K_BITS;

    // ====================
    // Per-tag request table
    // ====================

    t_line_addr addr_tbl  [N_TAGS];
    logic       phys_tbl  [N_TAGS];
    logic       spec_tbl  [N_TAGS];
    t_mdata     mdata_tbl [N_TAGS];

    always_ff @(posedge clk)
    begin
        if (alloc_valid)
        begin
            addr_tbl[alloc_tag]  <= alloc_addr;
            phys_tbl[alloc_tag]  <= alloc_phys;
            spec_tbl[alloc_tag]  <= alloc_spec;
            mdata_tbl[alloc_tag] <= alloc_mdata;
        end
    end

    // ====================
    // Physical address build
    // ====================

    t_line_addr ent_addr;
    logic       ent_phys;
    t_line_addr phys_addr;

    assign ent_addr = addr_tbl[lookup_rsp_tag];
    assign ent_phys = phys_tbl[lookup_rsp_tag];

    always_comb
    begin
        if (ent_phys)
        begin
            // Untranslated, keep what the requester sent
            phys_addr = ent_addr;
        end
        else if (lookup_rsp_big)
        begin
            phys_addr = {lookup_rsp_page[PAGE_4K_BITS-1:BIG_LOW_BITS],
                         ent_addr[OFFSET_2M_BITS-1:0]};
        end
        else
        begin
            phys_addr = {lookup_rsp_page, ent_addr[OFFSET_4K_BITS-1:0]};
        end
    end

    // Exactly one of memory read or error per lookup response
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            mem_req_valid <= 1'b0;
            err_valid     <= 1'b0;
            free_valid    <= 1'b0;
        end
        else
        begin
            mem_req_valid <= lookup_rsp_valid && (ent_phys || !lookup_rsp_error);
            err_valid     <= lookup_rsp_valid && !ent_phys && lookup_rsp_error;
            free_valid    <= lookup_rsp_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        free_tag      <= lookup_rsp_tag;
        mem_req_addr  <= phys_addr;
        mem_req_mdata <= mdata_tbl[lookup_rsp_tag];
        err_mdata     <= mdata_tbl[lookup_rsp_tag];
    end

    // Failed translation is legal only for a speculative lookup from decode
    a_err_only_spec: assert property (@(posedge clk) disable iff (!reset)
        (lookup_rsp_valid && lookup_rsp_error && !ent_phys) |-> spec_tbl[lookup_rsp_tag])
        else $error("Lookup error returned for a non-speculative read");

endmodule

`default_nettype wire

/* hw/vtp_rsp_result.sv */
// Response merge with error injection

`default_nettype none

module vtp_rsp_result
#(
    parameter int ERR_DEPTH = 8
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  err_valid,
    input  vtp_req_pkg::t_mdata   err_mdata,
    input  logic                  mem_rsp_valid,
    input  vtp_req_pkg::t_mdata   mem_rsp_mdata,
    input  logic [63:0]           mem_rsp_data,
    output logic                  rsp_valid,
    output vtp_req_pkg::t_mdata   rsp_mdata,
    output logic [63:0]           rsp_data,
    output logic                  rsp_error
);
    import vtp_req_pkg::*;

    localparam int PTR_BITS = (ERR_DEPTH > 1) ? $clog2(ERR_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(ERR_DEPTH + 1);

    // ====================
    // Error queue
    // ====================

    t_mdata              err_q [ERR_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] err_count;
    logic                err_deq;

    // Errors only take cycles that memory leaves idle
    assign err_deq = (err_count != '0) && !mem_rsp_valid;

    always_ff @(posedge clk)
    begin
        if (err_valid)
        begin
            err_q[wr_ptr] <= err_mdata;
        end
    end

    // Pointers wrap at ERR_DEPTH, which need not be a power of two
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            err_count <= '0;
        end
        else
        begin
            if (err_valid)
            begin
                wr_ptr <= (wr_ptr == PTR_BITS'(ERR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (err_deq)
            begin
                rd_ptr <= (rd_ptr == PTR_BITS'(ERR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            err_count <= err_count + CNT_BITS'(err_valid) - CNT_BITS'(err_deq);
        end
    end

    // ====================
    // Response stream
    // ====================

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            rsp_valid <= 1'b0;
            rsp_error <= 1'b0;
        end
        else
        begin
            rsp_valid <= mem_rsp_valid || err_deq;
            rsp_error <= err_deq;
        end
    end

    // Memory response has priority, error carries zero data
    always_ff @(posedge clk)
    begin
        rsp_mdata <= mem_rsp_valid ? mem_rsp_mdata : err_q[rd_ptr];
        rsp_data  <= mem_rsp_valid ? mem_rsp_data : '0;
    end

    // Queue must drain before execute pushes past its depth
    a_no_overflow: assert property (@(posedge clk) disable iff (!reset)
        err_valid |-> ((err_count < CNT_BITS'(ERR_DEPTH)) || err_deq))
        else $error("Error queue overflow");

endmodule

`default_nettype wire

/* hw/vtp_shim.sv */
// Address translation shim top

`default_nettype none

module vtp_shim
#(
    parameter int N_TAGS    = 16,
    parameter int ERR_DEPTH = 8
)
(
    input  logic                          clk,
    input  logic                          reset,
    // Requester
    input  logic                          req_valid,
    input  vtp_req_pkg::t_rd_op           req_op,
    input  vtp_addr_pkg::t_line_addr      req_addr,
    input  vtp_req_pkg::t_mdata           req_mdata,
    // Translation service
    output logic                          lookup_valid,
    output logic [$clog2(N_TAGS)-1:0]     lookup_tag,
    output vtp_addr_pkg::t_page_4k        lookup_page,
    output logic                          lookup_spec,
    input  logic                          lookup_rsp_valid,
    input  logic [$clog2(N_TAGS)-1:0]     lookup_rsp_tag,
    input  logic                          lookup_rsp_error,
    input  logic                          lookup_rsp_big,
    input  vtp_addr_pkg::t_page_4k        lookup_rsp_page,
    // Memory
    output logic                          mem_req_valid,
    output vtp_addr_pkg::t_line_addr      mem_req_addr,
    output vtp_req_pkg::t_mdata           mem_req_mdata,
    input  logic                          mem_rsp_valid,
    input  vtp_req_pkg::t_mdata           mem_rsp_mdata,
    input  logic [63:0]                   mem_rsp_data,
    // Responses back to the requester
    output logic                          rsp_valid,
    output vtp_req_pkg::t_mdata           rsp_mdata,
    output logic [63:0]                   rsp_data,
    output logic                          rsp_error
);
    import vtp_addr_pkg::*;
    import vtp_req_pkg::*;

    localparam int TAG_BITS = $clog2(N_TAGS);

    // Decode to execute
    logic                alloc_valid;
    logic [TAG_BITS-1:0] alloc_tag;
    t_line_addr          alloc_addr;
    logic                alloc_phys;
    logic                alloc_spec;
    t_mdata              alloc_mdata;

    // Execute back to decode, and on to result
    logic                free_valid;
    logic [TAG_BITS-1:0] free_tag;
    logic                err_valid;
    t_mdata              err_mdata;

    // ====================
    // Pipeline stages
    // ====================

    // Port names match the wires one to one
    vtp_req_decode #(.N_TAGS(N_TAGS)) decode_inst (.*);

    vtp_xlate_execute #(.N_TAGS(N_TAGS)) execute_inst (.*);

    vtp_rsp_result #(.ERR_DEPTH(ERR_DEPTH)) result_inst (.*);

endmodule

`default_nettype wire

/* bench/tb_vtp_tasks.svh */
// Shim directed tests and checks

`ifndef TB_VTP_TASKS_SVH
`define TB_VTP_TASKS_SVH

// ====================
// Random numbers
// ====================

// Galois LFSR, 32 bits, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

// One step per bit taken
task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
        state = lfsr_step(state);
        bits  = {bits[30:0], state[0]};
    end
endtask

// ====================
// Reference rules
// ====================

// Bit 20 marks a big page, bit 30 a failing speculative lookup
function automatic t_line_addr with_bits(input t_line_addr addr, input logic big,
                                         input logic fail);
    t_line_addr a;
    a     = addr;
    a[20] = big;
    a[30] = fail;
    return a;
endfunction

function automatic t_line_addr expected_phys(input t_rd_op op, input t_line_addr addr);
    t_page_4k ppage;
    ppage = addr[41:6] ^ PAGE_MASK;
    if (op == OP_RD_PHYS)
    begin
        return addr;
    end
    if (addr[20])
    begin
        // 2 MB page keeps 15 offset bits
        return {ppage[35:9], addr[14:0]};
    end
    return {ppage, addr[5:0]};
endfunction

// Read data is the metadata, a marker and the line address
function automatic logic [63:0] mem_data(input t_line_addr addr, input t_mdata mdata);
    return {mdata, 6'h2a, addr};
endfunction

function automatic int find_read(input t_mdata mdata);
    for (int i = 0; i < exp_reads.size(); i++)
    begin
        if (exp_reads[i].mdata == mdata)
        begin
            return i;
        end
    end
    return -1;
endfunction

function automatic int find_rsp(input t_mdata mdata);
    for (int i = 0; i < exp_rsps.size(); i++)
    begin
        if (exp_rsps[i].mdata == mdata)
        begin
            return i;
        end
    end
    return -1;
endfunction

// ====================
// Compare tasks
// ====================

task automatic check_addr(input string what, input t_line_addr exp, input t_line_addr act);
    if (exp !== act)
    begin
        $display("ERROR [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        value_errors++;
    end
endtask

task automatic check_mdata(input string what, input t_mdata exp, input t_mdata act);
    if (exp !== act)
    begin
        $display("ERROR [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        value_errors++;
    end
endtask

task automatic check_data(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
        $display("ERROR [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        value_errors++;
    end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act)
    begin
        $display("ERROR [%s] %s: expected %b, actual %b", test_name, what, exp, act);
        value_errors++;
    end
endtask

// ====================
// Stimulus helpers
// ====================

// One request per falling edge, expectations recorded before it is seen
task automatic send_req(input t_rd_op op, input t_line_addr addr);
    t_line_addr pa;
    @(negedge clk);
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_mdata = next_mdata;
    if (op == OP_RD_SPEC && addr[30])
    begin
        exp_rsps.push_back('{next_mdata, 64'h0, 1'b1});
    end
    else
    begin
        pa = expected_phys(op, addr);
        exp_reads.push_back('{pa, next_mdata});
        exp_rsps.push_back('{next_mdata, mem_data(pa, next_mdata), 1'b0});
    end
    next_mdata++;
endtask

task automatic end_burst();
    @(negedge clk);
    req_valid = 1'b0;
endtask

task automatic wait_done();
    while (exp_reads.size() != 0 || exp_rsps.size() != 0)
    begin
        @(posedge clk);
    end
    // Quiet period, a duplicate still lands in this test
    repeat (10) @(posedge clk);
endtask

// ====================
// Directed tests
// ====================

task automatic test_rd_4k();
    test_name = "rd_4k";
    send_req(OP_RD, with_bits(42'h1B3_C4D5_E67, 1'b0, 1'b0));
    // Fail bit means nothing to a plain read
    send_req(OP_RD, with_bits(42'h0A5_1234_0FF, 1'b0, 1'b1));
    end_burst();
    wait_done();
endtask

task automatic test_rd_big();
    test_name = "rd_big";
    send_req(OP_RD, with_bits(42'h2F0_9876_5A3, 1'b1, 1'b0));
    send_req(OP_RD, with_bits(42'h013_57F1_7C1, 1'b1, 1'b0));
    end_burst();
    wait_done();
endtask

task automatic test_rd_phys();
    test_name = "rd_phys";
    // Service claims a big page, the address still goes out as is
    send_req(OP_RD_PHYS, with_bits(42'h3C2_4681_ACE, 1'b1, 1'b1));
    send_req(OP_RD_PHYS, with_bits(42'h001_0203_040, 1'b0, 1'b0));
    end_burst();
    wait_done();
endtask

task automatic test_spec_fail();
    test_name = "spec_fail";
    send_req(OP_RD_SPEC, with_bits(42'h155_AA55_A5A, 1'b0, 1'b1));
    end_burst();
    wait_done();
    // Passing speculative read behaves like a plain one
    send_req(OP_RD_SPEC, with_bits(42'h0EE_7711_3C3, 1'b1, 1'b0));
    end_burst();
    wait_done();
endtask

task automatic test_random_burst();
    logic [31:0] opb;
    logic [31:0] lo;
    logic [31:0] hi;
    t_rd_op      op;
    test_name = "random_burst";
    for (int i = 0; i < N_TAGS; i++)
    begin
        draw_bits(stim_lfsr, 2, opb);
        draw_bits(stim_lfsr, 32, lo);
        draw_bits(stim_lfsr, 10, hi);
        op = (opb[1:0] == 2'd1) ? OP_RD_SPEC :
             (opb[1:0] == 2'd2) ? OP_RD_PHYS : OP_RD;
        send_req(op, {hi[9:0], lo});
    end
    end_burst();
    wait_done();
endtask

// Every third request fails amid a stream of normal reads
task automatic test_err_merge();
    t_line_addr addr;
    test_name = "err_merge";
    for (int i = 0; i < 12; i++)
    begin
        addr = {26'h2AB_CDE5, 10'(i * 37), 6'(i)};
        if (i % 3 == 2)
        begin
            send_req(OP_RD_SPEC, with_bits(addr, 1'b0, 1'b1));
        end
        else
        begin
            send_req(OP_RD, with_bits(addr, 1'b0, 1'b0));
        end
    end
    end_burst();
    wait_done();
endtask

`endif

/* bench/tb_vtp_shim.sv */
// Translation shim testbench

`default_nettype none

module tb_vtp_shim;
    timeunit 1ns;
    timeprecision 1ps;

    import vtp_addr_pkg::*;
    import vtp_req_pkg::*;

    localparam int N_TAGS          = 16;
    localparam int TAG_BITS        = $clog2(N_TAGS);
    localparam int CLK_PERIOD      = 20;
    localparam int N_TESTS         = 6;
    localparam int WATCHDOG_CYCLES = 200 * N_TESTS + 2000;
    localparam logic [31:0] SEED   = 32'd32501;

    // Fixed XOR between a virtual and a physical 4 KB page
    localparam t_page_4k PAGE_MASK = 36'h5_A5C3_96E1;

    // ====================
    // Model and scoreboard records
    // ====================

    // Lookup waiting in the service model
    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        t_page_4k            page;
        logic                spec;
        logic [31:0]         stamp;
    } lookup_ent_t;

    // Read waiting in the memory model
    typedef struct packed {
        t_line_addr  addr;
        t_mdata      mdata;
        logic [31:0] due;
    } mem_ent_t;

    typedef struct packed {
        t_line_addr addr;
        t_mdata     mdata;
    } read_ent_t;

    typedef struct packed {
        t_mdata      mdata;
        logic [63:0] data;
        logic        error;
    } rsp_ent_t;

    // ====================
    // DUT signals
    // ====================

    logic                clk;
    logic                reset;
    logic                req_valid;
    t_rd_op              req_op;
    t_line_addr          req_addr;
    t_mdata              req_mdata;
    logic                lookup_valid;
    logic [TAG_BITS-1:0] lookup_tag;
    t_page_4k            lookup_page;
    logic                lookup_spec;
    logic                lookup_rsp_valid;
    logic [TAG_BITS-1:0] lookup_rsp_tag;
    logic                lookup_rsp_error;
    logic                lookup_rsp_big;
    t_page_4k            lookup_rsp_page;
    logic                mem_req_valid;
    t_line_addr          mem_req_addr;
    t_mdata              mem_req_mdata;
    logic                mem_rsp_valid;
    t_mdata              mem_rsp_mdata;
    logic [63:0]         mem_rsp_data;
    logic                rsp_valid;
    t_mdata              rsp_mdata;
    logic [63:0]         rsp_data;
    logic                rsp_error;

    // Bench state
    string       test_name;
    int          value_errors;
    int          proto_errors;
    int          cyc;
    logic [31:0] svc_lfsr;
    logic [31:0] stim_lfsr;
    t_mdata      next_mdata;
    logic        mem_rsp_prev;
    t_mdata      mem_mdata_prev;
    lookup_ent_t pending [$];
    mem_ent_t    mem_q [$];
    read_ent_t   exp_reads [$];
    rsp_ent_t    exp_rsps [$];

    vtp_shim vtp_shim_inst (.*);

    `include "tb_vtp_tasks.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // Monitors, sampled at the rising edge
    // ====================

    always @(posedge clk)
    begin : monitor
        int idx;
        if (reset)
        begin
            // Service queues every lookup with its arrival cycle
            if (lookup_valid)
            begin
                pending.push_back('{lookup_tag, lookup_page, lookup_spec, cyc});
            end
            if (mem_req_valid)
            begin
                idx = find_read(mem_req_mdata);
                if (idx < 0)
                begin
                    $display("Unexpected memory read with metadata %h in %s",
                             mem_req_mdata, test_name);
                    proto_errors++;
                end
                else
                begin
                    check_addr("memory read address", exp_reads[idx].addr, mem_req_addr);
                    exp_reads.delete(idx);
                end
                // Memory answers four cycles later
                mem_q.push_back('{mem_req_addr, mem_req_mdata, cyc + 4});
            end
            if (rsp_valid)
            begin
                idx = find_rsp(rsp_mdata);
                if (idx < 0)
                begin
                    $display("Unexpected response with metadata %h in %s", rsp_mdata, test_name);
                    proto_errors++;
                end
                else
                begin
                    check_bit("response error flag", exp_rsps[idx].error, rsp_error);
                    check_data("response data", exp_rsps[idx].data, rsp_data);
                    exp_rsps.delete(idx);
                end
                // Normal response follows a memory response, error fills an idle slot
                check_bit("memory response in previous cycle", !rsp_error, mem_rsp_prev);
                if (!rsp_error)
                begin
                    check_mdata("response metadata", mem_mdata_prev, rsp_mdata);
                end
            end
            mem_rsp_prev   = mem_rsp_valid;
            mem_mdata_prev = mem_rsp_mdata;
        end
        cyc++;
    end

    // ====================
    // Service and memory models, driven at the falling edge
    // ====================

    always @(negedge clk)
    begin : models
        int          n_ready;
        int          idx;
        logic [31:0] bits;
        lookup_ent_t ent;
        lookup_rsp_valid = 1'b0;
        mem_rsp_valid    = 1'b0;
        // Older entries sit at the front, so ready ones form a prefix
        n_ready = 0;
        while (n_ready < pending.size() && (cyc - int'(pending[n_ready].stamp)) >= 2)
        begin
            n_ready++;
        end
        draw_bits(svc_lfsr, 2, bits);
        if (n_ready > 0 && bits[1:0] != 2'b00)
        begin
            draw_bits(svc_lfsr, 5, bits);
            idx = int'(bits[4:0]) % n_ready;
            ent = pending[idx];
            pending.delete(idx);
            lookup_rsp_valid = 1'b1;
            lookup_rsp_tag   = ent.tag;
            // Page bit 14 is address bit 20, page bit 24 is address bit 30
            lookup_rsp_error = ent.spec && ent.page[24];
            lookup_rsp_big   = ent.page[14];
            lookup_rsp_page  = ent.page ^ PAGE_MASK;
        end
        if (mem_q.size() > 0 && cyc >= int'(mem_q[0].due))
        begin
            mem_rsp_valid = 1'b1;
            mem_rsp_mdata = mem_q[0].mdata;
            mem_rsp_data  = mem_data(mem_q[0].addr, mem_q[0].mdata);
            void'(mem_q.pop_front());
        end
    end

    // ====================
    // Watchdog
    // ====================

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, the DUT stopped answering", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        clk              = 1'b0;
        reset            = 1'b0;
        req_valid        = 1'b0;
        req_op           = OP_RD;
        req_addr         = '0;
        req_mdata        = '0;
        lookup_rsp_valid = 1'b0;
        lookup_rsp_tag   = '0;
        lookup_rsp_error = 1'b0;
        lookup_rsp_big   = 1'b0;
        lookup_rsp_page  = '0;
        mem_rsp_valid    = 1'b0;
        mem_rsp_mdata    = '0;
        mem_rsp_data     = '0;
        value_errors     = 0;
        proto_errors     = 0;
        cyc              = 0;
        svc_lfsr         = SEED;
        stim_lfsr        = SEED;
        next_mdata       = 16'h0100;
        mem_rsp_prev     = 1'b0;
        mem_mdata_prev   = '0;
        test_name        = "reset";
        repeat (10) @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        test_rd_4k();
        test_rd_big();
        test_rd_phys();
        test_spec_fail();
        test_random_burst();
        test_err_merge();
        $display("Errors: %0d wrong values, %0d other failures", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+bench
hw/vtp_addr_pkg.sv
hw/vtp_req_pkg.sv
hw/vtp_req_decode.sv
hw/vtp_xlate_execute.sv
hw/vtp_rsp_result.sv
hw/vtp_shim.sv
bench/tb_vtp_shim.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_vtp_shim
RTL_TOP   ?= vtp_shim
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0 --timescale 1ns/1ps
LINTFLAGS ?= --lint-only -Wall --timescale 1ns/1ps
RTL_SRCS  ?= $(shell grep '^hw/' $(FILELIST))
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
